//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_radio_io_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := >>> FAIL
PASS_MSG  := >>> PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q -F '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q -F '$(PASS_MSG)' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
src/radio_pkg.sv
src/tx_sample_source.sv
src/rx_sample_fanout.sv
src/gpio_misc_retime.sv
src/radio_io_top.sv
verification/tb_radio_io_top.sv

//--- src/gpio_misc_retime.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_misc_retime (
   input  wire                                                   radio_clk,
   input  wire                                                   i_rst_n,
   input  wire [radio_pkg::FP_GPIO_W-1:0]                        i_tag_gpio_out,
   input  wire [radio_pkg::FP_GPIO_W-1:0]                        i_tag_gpio_ddr,
   input  wire [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] i_misc_out,
   input  wire [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] i_radio_misc_in,
   output logic [radio_pkg::FP_PORT_W-1:0]                       o_fp_gpio_out,
   output logic [radio_pkg::FP_PORT_W-1:0]                       o_fp_gpio_ddr,
   output logic [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] o_radio_misc_out,
   output logic [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] o_misc_in
);

   import radio_pkg::*;

   logic [FP_GPIO_W-1:0] gpio_out_q;
   logic [FP_GPIO_W-1:0] gpio_ddr_q;  // 1 = pin driven

   // ------------------------------
   // front panel and misc rank
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         gpio_out_q       <= '0;
         gpio_ddr_q       <= '0;
         o_radio_misc_out <= '0;
         o_misc_in        <= '0;
      end else begin
         gpio_out_q       <= i_tag_gpio_out;
         gpio_ddr_q       <= i_tag_gpio_ddr;
         o_radio_misc_out <= i_misc_out;       // toward the boards
         o_misc_in        <= i_radio_misc_in;  // from the boards
      end
   end

   // upper pins stay inputs driven low
   assign o_fp_gpio_out = {{(FP_PORT_W-FP_GPIO_W){1'b0}}, gpio_out_q};
   assign o_fp_gpio_ddr = {{(FP_PORT_W-FP_GPIO_W){1'b0}}, gpio_ddr_q};

   a_fp_upper_zero : assert property (
      @(posedge radio_clk) disable iff (!i_rst_n)
      (o_fp_gpio_out[FP_PORT_W-1:FP_GPIO_W] == '0) &&
      (o_fp_gpio_ddr[FP_PORT_W-1:FP_GPIO_W] == '0)
   ) else $error("front panel upper bits set");

endmodule : gpio_misc_retime

`default_nettype wire

//--- src/radio_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module radio_io_top (
   input  wire                                                   radio_clk,
   input  wire                                                   i_rst_n,
   // transmit
   input  wire                                                   i_tx_override,
   input  wire radio_pkg::iq_t                                   i_tag_i,
   input  wire radio_pkg::iq_t                                   i_tag_q,
   input  wire radio_pkg::sample_t [radio_pkg::NUM_CHANNELS-1:0] i_host_tx,
   input  wire [radio_pkg::NUM_CHANNELS-1:0]                     i_tx_stb,
   // receive
   input  wire radio_pkg::sample_t                               i_rx0,
   input  wire radio_pkg::sample_t                               i_rx1,
   input  wire [radio_pkg::NUM_CHANNELS-1:0]                     i_rx_running,
   // front panel and misc
   input  wire [radio_pkg::FP_GPIO_W-1:0]                        i_tag_gpio_out,
   input  wire [radio_pkg::FP_GPIO_W-1:0]                        i_tag_gpio_ddr,
   input  wire [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] i_misc_out,
   input  wire [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] i_radio_misc_in,
   // dac side
   output radio_pkg::sample_t                                    o_tx0,
   output radio_pkg::sample_t                                    o_tx1,
   // channel side
   output radio_pkg::sample_t [radio_pkg::NUM_CHANNELS-1:0]      o_rx_data,
   output logic [radio_pkg::NUM_CHANNELS-1:0]                    o_rx_stb,
   // pins
   output logic [radio_pkg::FP_PORT_W-1:0]                       o_fp_gpio_out,
   output logic [radio_pkg::FP_PORT_W-1:0]                       o_fp_gpio_ddr,
   output logic [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] o_radio_misc_out,
   output logic [radio_pkg::NUM_RADIOS-1:0][radio_pkg::MISC_W-1:0] o_misc_in
);

   // ------------------------------
   // transmit path
   // ------------------------------
   tx_sample_source u_tx (
      .radio_clk     (radio_clk),
      .i_rst_n       (i_rst_n),
      .i_tx_override (i_tx_override),
      .i_tag_i       (i_tag_i),
      .i_tag_q       (i_tag_q),
      .i_host_tx     (i_host_tx),
      .i_tx_stb      (i_tx_stb),
      .o_tx0         (o_tx0),
      .o_tx1         (o_tx1)
   );

   // ------------------------------
   // receive path
   // ------------------------------
   rx_sample_fanout u_rx (
      .radio_clk    (radio_clk),
      .i_rst_n      (i_rst_n),
      .i_rx0        (i_rx0),
      .i_rx1        (i_rx1),
      .i_rx_running (i_rx_running),
      .o_rx_data    (o_rx_data),
      .o_rx_stb     (o_rx_stb)
   );

   // front panel gpio from the tag controller, misc words both ways
   gpio_misc_retime u_io (
      .radio_clk        (radio_clk),
      .i_rst_n          (i_rst_n),
      .i_tag_gpio_out   (i_tag_gpio_out),
      .i_tag_gpio_ddr   (i_tag_gpio_ddr),
      .i_misc_out       (i_misc_out),
      .i_radio_misc_in  (i_radio_misc_in),
      .o_fp_gpio_out    (o_fp_gpio_out),
      .o_fp_gpio_ddr    (o_fp_gpio_ddr),
      .o_radio_misc_out (o_radio_misc_out),
      .o_misc_in        (o_misc_in)
   );

endmodule : radio_io_top

`default_nettype wire

//--- src/radio_pkg.sv
`default_nettype none

package radio_pkg;

   // ------------------------------
   // board and channel counts
   // ------------------------------
   localparam int NUM_RADIOS         = 2;  // daughterboards
   localparam int CHANNELS_PER_RADIO = 2;
   localparam int NUM_CHANNELS       = NUM_RADIOS * CHANNELS_PER_RADIO;

   // ------------------------------
   // word widths
   // ------------------------------
   // adc and dac words carry i in the upper half, q in the lower half
   localparam int SAMPLE_W = 32;
   localparam int IQ_W     = 16;  // one component

   localparam int MISC_W   = 32;  // per-board misc in/out

   // front panel: the tag controller drives the low pins only
   localparam int FP_GPIO_W = 12;
   localparam int FP_PORT_W = 32;

   // ------------------------------
   // payload types
   // ------------------------------
   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [IQ_W-1:0]     iq_t;

endpackage : radio_pkg

`default_nettype wire

//--- src/rx_sample_fanout.sv
`timescale 1ns/1ps
`default_nettype none

module rx_sample_fanout (
   input  wire                                                   radio_clk,
   input  wire                                                   i_rst_n,
   input  wire radio_pkg::sample_t                               i_rx0,
   input  wire radio_pkg::sample_t                               i_rx1,
   input  wire [radio_pkg::NUM_CHANNELS-1:0]                     i_rx_running,
   output radio_pkg::sample_t [radio_pkg::NUM_CHANNELS-1:0]      o_rx_data,
   output logic [radio_pkg::NUM_CHANNELS-1:0]                    o_rx_stb
);

   import radio_pkg::*;

   sample_t adc_q [NUM_RADIOS];  // one registered adc word per board

   // ------------------------------
   // adc capture
   // ------------------------------
   always_ff @(posedge radio_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         adc_q[0] <= '0;
         adc_q[1] <= '0;
         o_rx_stb <= '0;
      end else begin
         adc_q[0] <= i_rx0;
         adc_q[1] <= i_rx1;
         o_rx_stb <= i_rx_running;  // strobe only while the channel runs
      end
   end

   // both channels of a board see the same adc
   always_comb begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
         o_rx_data[ch] = adc_q[ch / CHANNELS_PER_RADIO];
      end
   end

   // ------------------------------
   // checks
   // ------------------------------
   for (genvar r = 0; r < NUM_RADIOS; r++) begin : g_chk
      for (genvar c = 1; c < CHANNELS_PER_RADIO; c++) begin : g_pair
         a_board_equal : assert property (
            @(posedge radio_clk) disable iff (!i_rst_n)
            o_rx_data[r*CHANNELS_PER_RADIO + c] == o_rx_data[r*CHANNELS_PER_RADIO]
         ) else $error("board %0d channel %0d data differs", r, c);
      end
   end

endmodule : rx_sample_fanout

`default_nettype wire

//--- src/tx_sample_source.sv
`timescale 1ns/1ps
`default_nettype none

module tx_sample_source (
   input  wire                                                   radio_clk,
   input  wire                                                   i_rst_n,
   input  wire                                                   i_tx_override,
   input  wire radio_pkg::iq_t                                   i_tag_i,
   input  wire radio_pkg::iq_t                                   i_tag_q,
   input  wire radio_pkg::sample_t [radio_pkg::NUM_CHANNELS-1:0] i_host_tx,
   input  wire [radio_pkg::NUM_CHANNELS-1:0]                     i_tx_stb,
   output radio_pkg::sample_t                                    o_tx0,
   output radio_pkg::sample_t                                    o_tx1
);

   import radio_pkg::*;

   sample_t tag_word;
   sample_t tx_sel   [NUM_CHANNELS];  // word offered to each hold register
   sample_t hold_q   [NUM_CHANNELS];
   sample_t dac_word [NUM_RADIOS];    // first channel of each board

   assign tag_word = {i_tag_i, i_tag_q};  // i high, q low

   // ------------------------------
   // per-channel select and hold
   // ------------------------------
   for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
      // tag controller takes over every channel when override is set
      assign tx_sel[ch] = i_tx_override ? tag_word : i_host_tx[ch];

      always_ff @(posedge radio_clk or negedge i_rst_n) begin
         if (!i_rst_n) begin
            hold_q[ch] <= '0;
         end else if (i_tx_stb[ch]) begin
            hold_q[ch] <= tx_sel[ch];  // held until the next strobe
         end
      end
   end

   // ------------------------------
   // dac mapping
   // ------------------------------
   // one dac per board, fed by the board's first channel.
   // the second channel of each board is kept but has no dac on this build
   for (genvar r = 0; r < NUM_RADIOS; r++) begin : g_dac
      assign dac_word[r] = hold_q[r*CHANNELS_PER_RADIO];

      // a dac word moves only in the cycle after its channel strobe
      a_dac_on_stb : assert property (
         @(posedge radio_clk) disable iff (!i_rst_n)
         (dac_word[r] != $past(dac_word[r])) |-> $past(i_tx_stb[r*CHANNELS_PER_RADIO])
      ) else $error("dac %0d changed without a strobe", r);
   end

   assign o_tx0 = dac_word[0];
   assign o_tx1 = dac_word[1];

endmodule : tx_sample_source

`default_nettype wire

//--- verification/tb_radio_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_radio_io_top;

   import radio_pkg::*;

   typedef logic [NUM_CHANNELS-1:0] chan_bits_t;
   typedef logic [FP_GPIO_W-1:0]    gpio_bits_t;

   localparam int RESET_CYCLES = 2;
   localparam int HOLD_CYCLES  = 20;  // tx idle stretch
   localparam int RAND_CYCLES  = 40;
   // fixed steps of the five tests add 12 cycles
   localparam int TEST_CYCLES  = RESET_CYCLES + HOLD_CYCLES + 2*RAND_CYCLES + 12;
   localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES + 100;

   logic                              radio_clk;
   logic                              i_rst_n;
   logic                              i_tx_override;
   iq_t                               i_tag_i;
   iq_t                               i_tag_q;
   sample_t [NUM_CHANNELS-1:0]        i_host_tx;
   chan_bits_t                        i_tx_stb;
   sample_t                           i_rx0;
   sample_t                           i_rx1;
   chan_bits_t                        i_rx_running;
   gpio_bits_t                        i_tag_gpio_out;
   gpio_bits_t                        i_tag_gpio_ddr;
   logic [NUM_RADIOS-1:0][MISC_W-1:0] i_misc_out;
   logic [NUM_RADIOS-1:0][MISC_W-1:0] i_radio_misc_in;
   sample_t                           o_tx0;
   sample_t                           o_tx1;
   sample_t [NUM_CHANNELS-1:0]        o_rx_data;
   chan_bits_t                        o_rx_stb;
   logic [FP_PORT_W-1:0]              o_fp_gpio_out;
   logic [FP_PORT_W-1:0]              o_fp_gpio_ddr;
   logic [NUM_RADIOS-1:0][MISC_W-1:0] o_radio_misc_out;
   logic [NUM_RADIOS-1:0][MISC_W-1:0] o_misc_in;

   // model registers
   sample_t              m_hold [NUM_CHANNELS];
   sample_t              m_adc  [NUM_RADIOS];
   chan_bits_t           m_rx_stb;
   gpio_bits_t           m_gpio_out;
   gpio_bits_t           m_gpio_ddr;
   logic [MISC_W-1:0]    m_misc_out [NUM_RADIOS];
   logic [MISC_W-1:0]    m_misc_in  [NUM_RADIOS];

   int err_count       = 0;
   int check_count     = 0;
   int test_count      = 0;
   int test_fail_count = 0;
   int cycle_count     = 0;

   radio_io_top dut0 (.*);

   initial begin
      radio_clk = 1'b0;
      forever #4 radio_clk = ~radio_clk;
   end

   // ------------------------------
   // reference model and compare
   // ------------------------------
   function automatic void ref_outputs();
      if (!i_rst_n) begin
         for (int ch = 0; ch < NUM_CHANNELS; ch++) m_hold[ch] = '0;
         for (int b = 0; b < NUM_RADIOS; b++) begin
            m_adc[b]      = '0;
            m_misc_out[b] = '0;
            m_misc_in[b]  = '0;
         end
         m_rx_stb   = '0;
         m_gpio_out = '0;
         m_gpio_ddr = '0;
      end else begin
         for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (i_tx_stb[ch])
               m_hold[ch] = i_tx_override ? {i_tag_i, i_tag_q} : i_host_tx[ch];
         end
         m_adc[0]   = i_rx0;
         m_adc[1]   = i_rx1;
         m_rx_stb   = i_rx_running;  // strobe is the running bit, one cycle on
         m_gpio_out = i_tag_gpio_out;
         m_gpio_ddr = i_tag_gpio_ddr;
         for (int b = 0; b < NUM_RADIOS; b++) begin
            m_misc_out[b] = i_misc_out[b];
            m_misc_in[b]  = i_radio_misc_in[b];
         end
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         err_count++;
         $display("CHECK FAILED %s expected %h got %h at %0t", name, expected, actual, $time);
      end
   endtask

   always @(posedge radio_clk) begin
      ref_outputs();  // inputs are stable here, driven on the falling edge
      #1;
      check_value("o_tx0", m_hold[0], o_tx0);  // dac 0 from channel 0
      check_value("o_tx1", m_hold[2], o_tx1);  // dac 1 from channel 2
      for (int ch = 0; ch < NUM_CHANNELS; ch++)
         check_value($sformatf("o_rx_data[%0d]", ch), m_adc[ch / CHANNELS_PER_RADIO],
                     o_rx_data[ch]);
      check_value("o_rx_stb", 32'(m_rx_stb), 32'(o_rx_stb));
      check_value("o_fp_gpio_out", 32'(m_gpio_out), o_fp_gpio_out);  // upper bits zero
      check_value("o_fp_gpio_ddr", 32'(m_gpio_ddr), o_fp_gpio_ddr);
      for (int b = 0; b < NUM_RADIOS; b++) begin
         check_value($sformatf("o_radio_misc_out[%0d]", b), m_misc_out[b], o_radio_misc_out[b]);
         check_value($sformatf("o_misc_in[%0d]", b), m_misc_in[b], o_misc_in[b]);
      end
   end

   always @(posedge radio_clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("timeout: tests still running after %0d cycles", cycle_count);
         $display(">>> FAIL");
         $finish;
      end
   end

   // ------------------------------
   // tests
   // ------------------------------
   task automatic finish_test(input string name, input int errs_before);
      test_count++;
      if (err_count == errs_before) begin
         $display("test %-14s ok", name);
      end else begin
         test_fail_count++;
         $display("test %-14s failed with %0d errors", name, err_count - errs_before);
      end
   endtask

   task automatic test_reset_zero();
      int errs;
      errs = err_count;
      i_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(negedge radio_clk);
      i_rst_n = 1'b1;
      repeat (3) @(negedge radio_clk);  // inputs still zero, outputs must stay zero
      finish_test("reset", errs);
   endtask

   task automatic test_tag_override();
      iq_t ti;
      iq_t tq;
      int  errs;
      errs = err_count;
      ti   = iq_t'($urandom);
      tq   = iq_t'($urandom);
      @(negedge radio_clk);
      i_tx_override = 1'b1;
      i_tag_i       = ti;
      i_tag_q       = tq;
      i_tx_stb      = 4'b0101;
      @(negedge radio_clk);
      i_tx_stb = '0;
      i_tag_i  = ~ti;  // tag moves on, dacs keep the loaded word
      i_tag_q  = ~tq;
      check_value("o_tx0", {ti, tq}, o_tx0);
      check_value("o_tx1", {ti, tq}, o_tx1);
      @(negedge radio_clk);
      check_value("o_tx0", {ti, tq}, o_tx0);
      finish_test("tag override", errs);
   endtask

   task automatic test_host_hold();
      sample_t h0;
      sample_t h2;
      int      errs;
      errs = err_count;
      @(negedge radio_clk);
      i_tx_override = 1'b0;
      for (int ch = 0; ch < NUM_CHANNELS; ch++) i_host_tx[ch] = $urandom;
      i_tx_stb = 4'b0101;
      h0       = i_host_tx[0];
      h2       = i_host_tx[2];
      @(negedge radio_clk);
      for (int ch = 0; ch < NUM_CHANNELS; ch++) i_host_tx[ch] = $urandom;
      i_tx_stb = 4'b1010;  // second channel of each board, no dac behind it
      check_value("o_tx0", h0, o_tx0);
      check_value("o_tx1", h2, o_tx1);
      @(negedge radio_clk);
      i_tx_stb = '0;
      check_value("o_tx0", h0, o_tx0);
      check_value("o_tx1", h2, o_tx1);
      repeat (HOLD_CYCLES) begin
         @(negedge radio_clk);
         i_tx_override = 1'($urandom);
         i_tag_i       = iq_t'($urandom);
         i_tag_q       = iq_t'($urandom);
         for (int ch = 0; ch < NUM_CHANNELS; ch++) i_host_tx[ch] = $urandom;
      end
      @(negedge radio_clk);
      check_value("o_tx0", h0, o_tx0);
      check_value("o_tx1", h2, o_tx1);
      finish_test("host and hold", errs);
   endtask

   task automatic test_rx_fanout();
      int errs;
      errs = err_count;
      repeat (RAND_CYCLES) begin
         @(negedge radio_clk);
         i_rx0        = $urandom;
         i_rx1        = $urandom;
         i_rx_running = chan_bits_t'($urandom);
      end
      @(negedge radio_clk);
      finish_test("rx fanout", errs);
   endtask

   task automatic test_gpio_misc();
      int errs;
      errs = err_count;
      repeat (RAND_CYCLES) begin
         @(negedge radio_clk);
         i_tag_gpio_out = gpio_bits_t'($urandom);
         i_tag_gpio_ddr = gpio_bits_t'($urandom);
         for (int b = 0; b < NUM_RADIOS; b++) begin
            i_misc_out[b]      = $urandom;
            i_radio_misc_in[b] = $urandom;
         end
      end
      @(negedge radio_clk);
      finish_test("gpio and misc", errs);
   endtask

   initial begin
      void'($urandom(727));
      i_rst_n         = 1'b0;
      i_tx_override   = 1'b0;
      i_tag_i         = '0;
      i_tag_q         = '0;
      i_host_tx       = '0;
      i_tx_stb        = '0;
      i_rx0           = '0;
      i_rx1           = '0;
      i_rx_running    = '0;
      i_tag_gpio_out  = '0;
      i_tag_gpio_ddr  = '0;
      i_misc_out      = '0;
      i_radio_misc_in = '0;

      test_reset_zero();
      test_tag_override();
      test_host_hold();
      test_rx_fanout();
      test_gpio_misc();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_count, test_fail_count, check_count, err_count);
      if (err_count == 0 && test_fail_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule : tb_radio_io_top

`default_nettype wire
